//--- all.f
cnn_pkg.sv
cnn_dot_product.sv
cnn_window_walker.sv
cnn_result_packer.sv
cnn_ctrl.sv
cnn_top.sv
tb_mem.sv
tb_cnn.sv

//--- Makefile
# Verilator build and run of the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_cnn
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_cnn.sv
// testbench top; test table sizes must stay within 4..64, result region checked one word past the end
`timescale 1ns/10ps
`default_nettype none

module tb_cnn;

  typedef enum logic [2:0] {FILL_RAND, FILL_HIGH, FILL_NEG, FILL_POS, FILL_ZERO} fill_t;

  // one table row
  typedef struct packed {
    cnn_pkg::dim_t rows;
    cnn_pkg::dim_t cols;
    fill_t         pix_mode;   // FILL_RAND or FILL_HIGH
    fill_t         wgt_mode;
    cnn_pkg::acc_t bias;
    logic          again;      // second go after done
  } test_t;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             go;
  cnn_pkg::cfg_t    cfg;
  logic             busy;
  logic             done;
  cnn_pkg::rd_req_t rd;
  cnn_pkg::rd_rsp_t rd_rsp;
  cnn_pkg::wr_req_t wr;
  logic             wr_ack;
  logic [1:0]       rd_dly;
  logic [1:0]       wr_dly;
  logic             ld_en;
  cnn_pkg::addr_t   ld_addr;
  cnn_pkg::pix_t    ld_data;

  test_t         tests [8];
  string         names [8];
  logic [31:0]   lfsr;
  cnn_pkg::pix_t pic_q [cnn_pkg::MAX_DIM*cnn_pkg::MAX_DIM];   // loaded picture
  cnn_pkg::wgt_t wgt_q [16];                                  // kernel, row major
  int            errors;
  int            checks;
  int            ntests;
  bit            timed_out;

  always #10 clk = ~clk;   // 20 ns period

  cnn_top uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .cfg    (cfg),
    .go     (go),
    .busy   (busy),
    .done   (done),
    .rd     (rd),
    .rd_rsp (rd_rsp),
    .wr     (wr),
    .wr_ack (wr_ack)
  );

  tb_mem mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd      (rd),
    .rd_rsp  (rd_rsp),
    .wr      (wr),
    .wr_ack  (wr_ack),
    .rd_dly  (rd_dly),
    .wr_dly  (wr_dly),
    .ld_en   (ld_en),
    .ld_addr (ld_addr),
    .ld_data (ld_data)
  );

  // ==================================================
  // helpers
  // ==================================================
  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic cnn_pkg::pix_t guard_byte(input cnn_pkg::addr_t a);
    return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]} ^ 8'h5a;   // marks unwritten bytes
  endfunction

  task automatic check_value(input string what, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // strobes and request lines all low while no run is going
  task automatic check_idle();
    check_value("busy when idle", int'(busy), 0);
    check_value("done when idle", int'(done), 0);
    check_value("read request when idle", int'(rd.req), 0);
    check_value("write request when idle", int'(wr.req), 0);
  endtask

  task automatic load_byte(input cnn_pkg::addr_t a, input cnn_pkg::pix_t d);
    @(posedge clk);
    ld_en   <= 1'b1;
    ld_addr <= a;
    ld_data <= d;
  endtask

  task automatic load_end();
    @(posedge clk);
    ld_en <= 1'b0;
  endtask

  // picture, kernel and bias into memory and into the shadow arrays
  task automatic fill_inputs(input test_t tc);
    logic [31:0] r;
    for (int i = 0; i < int'(tc.rows) * int'(tc.cols); i++)
    begin
      if (tc.pix_mode == FILL_HIGH)
        pic_q[i] = 8'hc0 | cnn_pkg::pix_t'(rand_bits(6));
      else
        pic_q[i] = cnn_pkg::pix_t'(rand_bits(8));
      load_byte(cfg.addr_pic + cnn_pkg::addr_t'(i), pic_q[i]);
    end
    for (int i = 0; i < 16; i++)
    begin
      r = rand_bits(3);
      case (tc.wgt_mode)
        FILL_NEG:  wgt_q[i] = 8'hff - {5'b0, r[2:0]};   // -1..-8
        FILL_POS:  wgt_q[i] = {5'b0, r[2:0]} + 8'sd1;   // 1..8
        FILL_ZERO: wgt_q[i] = '0;
        default:   wgt_q[i] = {{5{r[2]}}, r[2:0]};      // -4..3
      endcase
      load_byte(cfg.addr_wgt + cnn_pkg::addr_t'(i), wgt_q[i]);
    end
    for (int k = 0; k < 4; k++)
      load_byte(cfg.addr_bias + cnn_pkg::addr_t'(k), tc.bias[k*8 +: 8]);   // little endian
    load_end();
  endtask

  task automatic clear_results(input test_t tc);
    int n;
    n = (int'(tc.rows) - 3) * (int'(tc.cols) - 3);
    for (int i = 0; i < ((n + 3) / 4 + 1) * 4; i++)
      load_byte(cfg.addr_res + cnn_pkg::addr_t'(i), guard_byte(cfg.addr_res + cnn_pkg::addr_t'(i)));
    load_end();
  endtask

  // reference: bias plus 4x4 window sum, clamped
  function automatic int window_byte(input test_t tc, input int w);
    int oc;
    int r;
    int c;
    int s;
    oc = int'(tc.cols) - 3;
    r  = w / oc;
    c  = w % oc;
    s  = tc.bias;
    for (int kr = 0; kr < 4; kr++)
      for (int kc = 0; kc < 4; kc++)
        s += int'(pic_q[(r + kr) * int'(tc.cols) + c + kc]) * int'(wgt_q[kr*4 + kc]);
    if (s < 0)
      return 0;
    else if (s > 255)
      return 255;
    return s;
  endfunction

  task automatic check_results(input test_t tc);
    int             n;
    int             nw;
    int             exp;
    cnn_pkg::addr_t a;
    n  = (int'(tc.rows) - 3) * (int'(tc.cols) - 3);
    nw = (n + 3) / 4;
    for (int i = 0; i < nw * 4 + 4; i++)
    begin
      a = cfg.addr_res + cnn_pkg::addr_t'(i);
      if (i < n)
        exp = window_byte(tc, i);
      else if (i < nw * 4)
        exp = 0;                  // padded tail lanes
      else
        exp = int'(guard_byte(a));   // word past the end untouched
      check_value($sformatf("result byte %0d", i), int'(mem.mem_q[a]), exp);
    end
  endtask

  // go pulse, then watch busy/done and the read channel every cycle until done
  task automatic run_once(input int limit);
    int cyc;
    bit seen;
    bit rd_open;   // read issued, response not back yet
    cyc     = 0;
    seen    = 1'b0;
    rd_open = 1'b0;
    @(negedge clk);
    check_idle();
    @(posedge clk);
    go <= 1'b1;
    @(posedge clk);
    go <= 1'b0;
    while (!seen && cyc < limit)
    begin
      @(negedge clk);
      if (rd_rsp.valid)
        rd_open = 1'b0;
      if (rd.req)
      begin
        check_value("read issued while one is outstanding", int'(rd_open), 0);
        rd_open = 1'b1;
      end
      if (done)
      begin
        seen = 1'b1;
        check_value("busy with done", int'(busy), 0);   // busy falls with done
      end
      else
        check_value("busy while running", int'(busy), 1);
      @(posedge clk);
      rd_dly <= 2'(rand_bits(2));
      wr_dly <= 2'(rand_bits(2));
      cyc++;
    end
    if (!seen)
    begin
      timed_out = 1'b1;
      $display("timeout: done did not arrive within %0d cycles", limit);
    end
    else
    begin
      @(negedge clk);
      check_value("done pulse width", int'(done), 0);
    end
  endtask

  task automatic run_test(input int t);
    test_t tc;
    int    e0;
    int    limit;
    tc    = tests[t];
    e0    = errors;
    limit = int'(tc.rows) * int'(tc.cols) * 40 + 2000;
    @(posedge clk);
    cfg.rows <= tc.rows;
    cfg.cols <= tc.cols;
    fill_inputs(tc);
    for (int r = 0; r < (tc.again ? 2 : 1) && !timed_out; r++)
    begin
      clear_results(tc);
      run_once(limit);
      if (!timed_out)
        check_results(tc);
    end
    ntests++;
    if (errors == e0 && !timed_out)
      $display("test %0d %s: ok", t, names[t]);
    else
      $display("test %0d %s: failed with %0d bad checks", t, names[t], errors - e0);
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial
  begin
    rst_n  = 1'b0;
    go     = 1'b0;
    rd_dly = '0;
    wr_dly = '0;
    ld_en  = 1'b0;
    ld_addr = '0;
    ld_data = '0;
    cfg    = '0;
    cfg.addr_pic  = 19'h01000;   // up to 64x64 bytes
    cfg.addr_wgt  = 19'h00100;
    cfg.addr_bias = 19'h00200;
    cfg.addr_res  = 19'h04000;
    lfsr      = 32'h653d_5d9d;
    errors    = 0;
    checks    = 0;
    ntests    = 0;
    timed_out = 1'b0;

    tests[0] = '{7'd4,  7'd4,  FILL_RAND, FILL_RAND, 32'sd100,  1'b0};
    names[0] = "single window";
    tests[1] = '{7'd7,  7'd9,  FILL_RAND, FILL_RAND, -32'sd20,  1'b0};
    names[1] = "packing across rows";
    tests[2] = '{7'd8,  7'd8,  FILL_HIGH, FILL_NEG,  32'sd10,   1'b0};
    names[2] = "clamp to zero";
    tests[3] = '{7'd6,  7'd10, FILL_HIGH, FILL_POS,  32'sd1000, 1'b0};
    names[3] = "clamp to 255";
    tests[4] = '{7'd5,  7'd7,  FILL_RAND, FILL_ZERO, 32'sd77,   1'b0};
    names[4] = "bias only";
    tests[5] = '{7'd5,  7'd5,  FILL_RAND, FILL_ZERO, -32'sd5,   1'b0};
    names[5] = "negative bias";
    tests[6] = '{7'd6,  7'd6,  FILL_RAND, FILL_RAND, 32'sd40,   1'b1};
    names[6] = "second go after done";
    tests[7] = '{7'd64, 7'd64, FILL_RAND, FILL_RAND, 32'sd200,  1'b0};
    names[7] = "full size picture";

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle();   // state right after reset

    for (int t = 0; t < $size(tests) && !timed_out; t++)
      run_test(t);

    $display("%0d tests run, %0d checks, %0d failed", ntests, checks, errors);
    if (errors == 0 && !timed_out)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_mem.sv
// byte memory for the testbench; read latency 1..4 and write ack delay 0..3 set by rd_dly and wr_dly
`timescale 1ns/10ps
`default_nettype none

module tb_mem (
  input  logic             clk,
  input  logic             rst_n,
  input  cnn_pkg::rd_req_t rd,
  output cnn_pkg::rd_rsp_t rd_rsp,
  input  cnn_pkg::wr_req_t wr,
  output logic             wr_ack,
  input  logic [1:0]       rd_dly,    // extra cycles for a new read
  input  logic [1:0]       wr_dly,    // extra cycles before a new ack
  input  logic             ld_en,     // backdoor byte load
  input  cnn_pkg::addr_t   ld_addr,
  input  cnn_pkg::pix_t    ld_data
);

  cnn_pkg::pix_t  mem_q [2**cnn_pkg::ADDR_W];
  logic           rd_busy;     // read accepted, not yet answered
  logic [1:0]     rd_cnt;
  cnn_pkg::addr_t rd_addr_q;
  cnn_pkg::addr_t rd_addr;
  logic           rd_fire;     // answer registered this edge
  logic           rd_valid_q;
  cnn_pkg::word_t rd_data_q;
  logic           wr_wait;
  logic [1:0]     wr_cnt;
  logic           wr_fire;     // ack registered this edge

  assign rd_fire = (rd.req && rd_dly == 2'd0) || (rd_busy && rd_cnt == 2'd0);
  assign rd_addr = rd.req ? rd.addr : rd_addr_q;
  assign wr_fire = wr.req && !wr_ack && (wr_wait ? (wr_cnt == 2'd0) : (wr_dly == 2'd0));

  assign rd_rsp.valid = rd_valid_q;
  assign rd_rsp.data  = rd_data_q;

  // ==================================================
  // latency counters
  // ==================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_busy    <= 1'b0;
      rd_cnt     <= '0;
      rd_addr_q  <= '0;
      rd_valid_q <= 1'b0;
      wr_wait    <= 1'b0;
      wr_cnt     <= '0;
      wr_ack     <= 1'b0;
    end
    else
    begin
      rd_valid_q <= rd_fire;   // one pulse per request
      wr_ack     <= wr_fire;
      if (rd.req && !rd_fire)
      begin
        rd_busy   <= 1'b1;
        rd_cnt    <= rd_dly - 2'd1;
        rd_addr_q <= rd.addr;
      end
      else if (rd_fire)
        rd_busy <= 1'b0;
      else if (rd_busy)
        rd_cnt <= rd_cnt - 2'd1;
      if (wr_fire)
        wr_wait <= 1'b0;
      else if (wr.req && !wr_ack && !wr_wait)
      begin
        wr_wait <= 1'b1;   // delay taken when req first seen
        wr_cnt  <= wr_dly - 2'd1;
      end
      else if (wr_wait)
        wr_cnt <= wr_cnt - 2'd1;
    end
  end

  // storage, byte addr in the low lane
  always_ff @(posedge clk)
  begin
    if (ld_en)
      mem_q[ld_addr] <= ld_data;
    for (int i = 0; i < cnn_pkg::KSIZE; i++)
    begin
      if (wr_fire)
        mem_q[wr.addr + cnn_pkg::addr_t'(i)] <= wr.data[i*cnn_pkg::BYTE_W +: cnn_pkg::BYTE_W];
      if (rd_fire)
        rd_data_q[i*cnn_pkg::BYTE_W +: cnn_pkg::BYTE_W] <= mem_q[rd_addr + cnn_pkg::addr_t'(i)];
    end
  end

endmodule

`default_nettype wire

//--- cnn_top.sv
// single-channel 4x4 convolution, stride 1, bias and 0..255 clamp; cfg stable while busy
`timescale 1ns/10ps
`default_nettype none

module cnn_top (
  input  logic             clk,
  input  logic             rst_n,
  input  cnn_pkg::cfg_t    cfg,
  input  logic             go,
  output logic             busy,
  output logic             done,
  output cnn_pkg::rd_req_t rd,
  input  cnn_pkg::rd_rsp_t rd_rsp,
  output cnn_pkg::wr_req_t wr,
  input  logic             wr_ack
);

  cnn_pkg::addr_t row_addr;
  logic [1:0]     krow;
  logic           win_last;
  logic           pic_last;
  logic           row_valid;
  logic           bias_valid;
  cnn_pkg::word_t kernel [cnn_pkg::KSIZE];
  logic           start;
  logic           word_ready;
  logic           dp_valid;
  cnn_pkg::acc_t  dp_res;

  // ==================================================
  // sequencing and read channel
  // ==================================================
  cnn_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .go         (go),
    .cfg        (cfg),
    .row_addr   (row_addr),
    .rd_rsp     (rd_rsp),
    .word_ready (word_ready),
    .pic_last   (pic_last),
    .wr_ack     (wr_ack),
    .rd         (rd),
    .row_valid  (row_valid),
    .bias_valid (bias_valid),
    .kernel     (kernel),
    .start      (start),
    .busy       (busy),
    .done       (done)
  );

  cnn_window_walker u_walker (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg       (cfg),
    .row_valid (row_valid),
    .row_addr  (row_addr),
    .krow      (krow),
    .win_last  (win_last),
    .pic_last  (pic_last)
  );

  // row data straight from the response, kernel row picked by krow
  cnn_dot_product u_dp (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_valid (row_valid),
    .pix_row   (rd_rsp.data),
    .wgt_row   (kernel[krow]),
    .dp_valid  (dp_valid),
    .dp_res    (dp_res)
  );

  cnn_result_packer u_packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .cfg        (cfg),
    .bias_valid (bias_valid),
    .bias       (cnn_pkg::acc_t'(rd_rsp.data)),
    .dp_valid   (dp_valid),
    .dp_res     (dp_res),
    .win_last   (win_last),
    .pic_last   (pic_last),
    .wr_ack     (wr_ack),
    .word_ready (word_ready),
    .wr         (wr)
  );

endmodule

`default_nettype wire

//--- cnn_ctrl.sv
// go is taken only in IDLE; one read outstanding at a time; missing wr_ack stalls in WRITE
`timescale 1ns/10ps
`default_nettype none

module cnn_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             go,
  input  cnn_pkg::cfg_t    cfg,
  input  cnn_pkg::addr_t   row_addr,     // from the walker
  input  cnn_pkg::rd_rsp_t rd_rsp,
  input  logic             word_ready,
  input  logic             pic_last,
  input  logic             wr_ack,
  output cnn_pkg::rd_req_t rd,
  output logic             row_valid,    // picture row in rd_rsp.data
  output logic             bias_valid,   // bias in rd_rsp.data
  output cnn_pkg::word_t   kernel [cnn_pkg::KSIZE],
  output logic             start,
  output logic             busy,
  output logic             done
);

  cnn_pkg::ctrl_state_t state;
  logic [1:0] wcnt;       // kernel row being loaded
  logic       rd_pend;    // load read issued, waiting
  logic [1:0] pipe;       // row response moving through dp and packer
  logic       pic_done;   // last picture row consumed

  assign start      = (state == cnn_pkg::IDLE) && go;
  assign row_valid  = (state == cnn_pkg::WAIT) && rd_rsp.valid;
  assign bias_valid = (state == cnn_pkg::LOAD_BIAS) && rd_pend && rd_rsp.valid;

  // ==================================================
  // read channel, single shared port
  // ==================================================
  always_comb
  begin
    rd.req  = 1'b0;
    rd.addr = row_addr;
    case (state)
      cnn_pkg::LOAD_WGT:
      begin
        rd.req  = !rd_pend;
        rd.addr = cfg.addr_wgt + cnn_pkg::addr_t'({wcnt, 2'b00});   // 4 bytes per row
      end
      cnn_pkg::LOAD_BIAS:
      begin
        rd.req  = !rd_pend;
        rd.addr = cfg.addr_bias;
      end
      cnn_pkg::READ: rd.req = !word_ready;   // pending word goes first
      default: rd.req = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (state == cnn_pkg::LOAD_WGT && rd_pend && rd_rsp.valid)
      kernel[wcnt] <= rd_rsp.data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= cnn_pkg::IDLE;
      wcnt     <= '0;
      rd_pend  <= 1'b0;
      pipe     <= '0;
      pic_done <= 1'b0;
      busy     <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      pipe <= {pipe[0], row_valid};
      if (pic_last)
        pic_done <= 1'b1;
      case (state)
        cnn_pkg::IDLE:
          if (go)
          begin
            state    <= cnn_pkg::LOAD_WGT;
            busy     <= 1'b1;
            wcnt     <= '0;
            rd_pend  <= 1'b0;
            pic_done <= 1'b0;
          end
        cnn_pkg::LOAD_WGT:
          if (!rd_pend)
            rd_pend <= 1'b1;
          else if (rd_rsp.valid)
          begin
            rd_pend <= 1'b0;
            wcnt    <= wcnt + 2'd1;
            if (wcnt == 2'd3)
              state <= cnn_pkg::LOAD_BIAS;
          end
        cnn_pkg::LOAD_BIAS:
          if (!rd_pend)
            rd_pend <= 1'b1;
          else if (rd_rsp.valid)
          begin
            rd_pend <= 1'b0;
            state   <= cnn_pkg::READ;
          end
        cnn_pkg::READ: state <= word_ready ? cnn_pkg::WRITE : cnn_pkg::WAIT;
        cnn_pkg::WAIT:
          if (pipe[1])
            state <= cnn_pkg::READ;   // packer has taken the row by now
        cnn_pkg::WRITE:
          if (wr_ack)
          begin
            if (pic_done)
            begin
              state <= cnn_pkg::FINISH;
              busy  <= 1'b0;
              done  <= 1'b1;
            end
            else
              state <= cnn_pkg::READ;
          end
        cnn_pkg::FINISH: state <= cnn_pkg::IDLE;
        default: state <= cnn_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cnn_result_packer.sv
// bytes packed low lane first; a partial last word is zero padded; wr held until wr_ack
`timescale 1ns/10ps
`default_nettype none

module cnn_result_packer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  cnn_pkg::cfg_t    cfg,
  input  logic             bias_valid,
  input  cnn_pkg::acc_t    bias,
  input  logic             dp_valid,
  input  cnn_pkg::acc_t    dp_res,
  input  logic             win_last,    // with dp_valid, last row of the window
  input  logic             pic_last,    // with dp_valid, last row of the picture
  input  logic             wr_ack,
  output logic             word_ready,  // word waiting for write
  output cnn_pkg::wr_req_t wr
);

  cnn_pkg::acc_t  bias_q;
  cnn_pkg::acc_t  acc;         // running window sum
  cnn_pkg::acc_t  win_sum;     // finished window plus bias
  cnn_pkg::pix_t  act_byte;
  logic           byte_vld;    // act_byte valid this cycle
  logic           last_byte;   // ...and it is the picture's last
  logic [1:0]     lane;        // next free byte lane
  cnn_pkg::addr_t waddr;
  cnn_pkg::word_t wdata;

  // ==================================================
  // activation, clamp to 0..255
  // ==================================================
  always_comb
  begin
    if (win_sum < 0)
      act_byte = '0;
    else if (win_sum > 255)
      act_byte = 8'hff;
    else
      act_byte = win_sum[7:0];
  end

  always_ff @(posedge clk)
  begin
    if (bias_valid)
      bias_q <= bias;
    if (dp_valid && win_last)
      win_sum <= acc + dp_res + bias_q;   // 4th row closes the window
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc        <= '0;
      byte_vld   <= 1'b0;
      last_byte  <= 1'b0;
      lane       <= '0;
      word_ready <= 1'b0;
      waddr      <= '0;
      wdata      <= '0;
    end
    else if (start)
    begin
      acc        <= '0;
      byte_vld   <= 1'b0;
      last_byte  <= 1'b0;
      lane       <= '0;
      word_ready <= 1'b0;
      waddr      <= cfg.addr_res;
      wdata      <= '0;
    end
    else
    begin
      byte_vld  <= dp_valid && win_last;
      last_byte <= dp_valid && pic_last;
      if (dp_valid)
        acc <= win_last ? '0 : acc + dp_res;
      if (byte_vld)
      begin
        wdata[{lane, 3'b000} +: cnn_pkg::BYTE_W] <= act_byte;
        lane <= lane + 2'd1;   // wraps after a full word
        if (lane == 2'd3 || last_byte)
          word_ready <= 1'b1;
      end
      else if (word_ready && wr_ack)
      begin
        word_ready <= 1'b0;
        wdata      <= '0;   // clean lanes for the next word
        waddr      <= waddr + cnn_pkg::addr_t'(cnn_pkg::KSIZE);
      end
    end
  end

  assign wr.req  = word_ready;
  assign wr.addr = waddr;
  assign wr.data = wdata;

endmodule

`default_nettype wire

//--- cnn_window_walker.sv
// stride fixed at 1; rows and cols must be at least 4 and cfg stable while busy
`timescale 1ns/10ps
`default_nettype none

module cnn_window_walker (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,       // clears the walk
  input  cnn_pkg::cfg_t  cfg,
  input  logic           row_valid,   // one picture row taken
  output cnn_pkg::addr_t row_addr,    // address of the next row to read
  output logic [1:0]     krow,        // kernel row for the current read
  output logic           win_last,    // aligned with dp_valid
  output logic           pic_last     // aligned with dp_valid
);

  cnn_pkg::dim_t org_row;   // window origin
  cnn_pkg::dim_t org_col;
  cnn_pkg::dim_t row_sel;   // picture row being read
  cnn_pkg::dim_t last_org_row;
  cnn_pkg::dim_t last_org_col;
  logic          row_end;   // origin at the last column
  logic          last_win;

  // ==================================================
  // address of picture byte (org_row+krow, org_col)
  // ==================================================
  assign row_sel  = org_row + cnn_pkg::dim_t'(krow);
  assign row_addr = cfg.addr_pic
                  + cnn_pkg::addr_t'(row_sel) * cnn_pkg::addr_t'(cfg.cols)
                  + cnn_pkg::addr_t'(org_col);

  assign last_org_row = cfg.rows - cnn_pkg::dim_t'(cnn_pkg::KSIZE);
  assign last_org_col = cfg.cols - cnn_pkg::dim_t'(cnn_pkg::KSIZE);
  assign row_end      = (org_col == last_org_col);   // next col would be cols-3
  assign last_win     = row_end && (org_row == last_org_row);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      org_row  <= '0;
      org_col  <= '0;
      krow     <= '0;
      win_last <= 1'b0;
      pic_last <= 1'b0;
    end
    else if (start)
    begin
      org_row  <= '0;
      org_col  <= '0;
      krow     <= '0;
      win_last <= 1'b0;
      pic_last <= 1'b0;
    end
    else
    begin
      // flags delayed one cycle to line up with the dot product result
      win_last <= row_valid && (krow == 2'd3);
      pic_last <= row_valid && (krow == 2'd3) && last_win;
      if (row_valid)
      begin
        krow <= krow + 2'd1;   // wraps after the 4th row
        if (krow == 2'd3)
        begin
          if (row_end)
          begin
            org_col <= '0;            // next window row
            org_row <= org_row + 1'b1;
          end
          else
            org_col <= org_col + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- cnn_dot_product.sv
// pixel bytes are unsigned, weight bytes signed; new row may enter every cycle
`timescale 1ns/10ps
`default_nettype none

module cnn_dot_product (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           row_valid,   // pix_row and wgt_row valid
  input  cnn_pkg::word_t pix_row,
  input  cnn_pkg::word_t wgt_row,
  output logic           dp_valid,    // one cycle after row_valid
  output cnn_pkg::acc_t  dp_res
);

  cnn_pkg::pix_t px   [cnn_pkg::KSIZE];
  cnn_pkg::wgt_t wt   [cnn_pkg::KSIZE];
  cnn_pkg::acc_t sum;

  // 4 lanes, 9-bit signed pixel times 8-bit weight
  always_comb
  begin
    sum = '0;
    for (int i = 0; i < cnn_pkg::KSIZE; i++)
    begin
      px[i] = pix_row[i*cnn_pkg::BYTE_W +: cnn_pkg::BYTE_W];
      wt[i] = cnn_pkg::wgt_t'(wgt_row[i*cnn_pkg::BYTE_W +: cnn_pkg::BYTE_W]);
      sum   = sum + cnn_pkg::acc_t'(signed'({1'b0, px[i]})) * cnn_pkg::acc_t'(wt[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      dp_valid <= 1'b0;
    else
      dp_valid <= row_valid;   // flag follows the data
  end

  always_ff @(posedge clk)
  begin
    if (row_valid)
      dp_res <= sum;
  end

endmodule

`default_nettype wire

//--- cnn_pkg.sv
// fixed 4x4 kernel and 4-byte reads, pictures from 4x4 up to 64x64, byte addresses of 19 bits
`default_nettype none

package cnn_pkg;

  // ==================================================
  // sizes
  // ==================================================
  localparam int KSIZE   = 4;                     // kernel side, lane count, bytes per read
  localparam int MAX_DIM = 64;                    // largest picture side
  localparam int ADDR_W  = 19;                    // byte address width
  localparam int DIM_W   = $clog2(MAX_DIM) + 1;   // holds MAX_DIM itself
  localparam int BYTE_W  = 8;
  localparam int WORD_W  = BYTE_W * KSIZE;        // one memory word

  // ==================================================
  // scalar types
  // ==================================================
  typedef logic        [ADDR_W-1:0] addr_t;    // byte address
  typedef logic        [DIM_W-1:0]  dim_t;     // row or column count
  typedef logic        [BYTE_W-1:0] pix_t;     // unsigned pixel
  typedef logic signed [BYTE_W-1:0] wgt_t;     // signed weight
  typedef logic signed [31:0]       acc_t;     // window sum, bias
  typedef logic        [WORD_W-1:0] word_t;    // 4 bytes, byte 0 in the low lane

  // software setup, 90 bits
  typedef struct packed {
    addr_t addr_pic;    // picture base
    addr_t addr_wgt;    // 16 weight bytes, row major
    addr_t addr_bias;   // one signed 32-bit word
    addr_t addr_res;    // result bytes, word aligned
    dim_t  rows;
    dim_t  cols;
  } cfg_t;

  // read request, req is a single-cycle pulse
  typedef struct packed {
    logic  req;
    addr_t addr;
  } rd_req_t;

  // read response, one valid pulse per request
  typedef struct packed {
    logic  valid;
    word_t data;
  } rd_rsp_t;

  // write request, held until ack
  typedef struct packed {
    logic  req;
    addr_t addr;
    word_t data;
  } wr_req_t;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOAD_WGT  = 3'd1,   // four kernel rows
    LOAD_BIAS = 3'd2,
    READ      = 3'd3,   // issue one picture row read, or go write
    WAIT      = 3'd4,   // response plus pipeline drain
    WRITE     = 3'd5,
    FINISH    = 3'd6
  } ctrl_state_t;

endpackage

`default_nettype wire
